/* Makefile */
VERILATOR ?= verilator
TOP       ?= arm_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* arm_clock_gen.sv */
module arm_clock_gen (
    output logic clk_o
  , output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    // Release on a falling edge, like all other stimulus
    @(negedge clk_o);
    reset_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

/* arm_consts.svh */
`ifndef ARM_CONSTS_SVH
`define ARM_CONSTS_SVH

// Register file and datapath sizes
`define ARM_NUM_REGS 16
`define ARM_XLEN 32
`define ARM_REG_AW 4

// Instruction field positions
`define ARM_COND_LSB 28
`define ARM_CLASS_LSB 25
`define ARM_OPC_LSB 21
`define ARM_S_BIT 20
`define ARM_RN_LSB 16
`define ARM_RD_LSB 12

`endif

/* arm_core.sv */
`include "arm_consts.svh"

module arm_core (
    input                          clk_i
  , input                          reset_i
  , input                          inst_valid_i
  , input        [`ARM_XLEN-1:0]   inst_i
  , output logic                   wb_valid_o
  , output logic                   wb_write_o
  , output logic [`ARM_REG_AW-1:0] wb_addr_o
  , output logic [`ARM_XLEN-1:0]   wb_data_o
  , output arm_pkg::flags_t        flags_o
);

  // Writeback bus back into decode and execute
  logic                   wb_en;
  logic [`ARM_REG_AW-1:0] wb_addr;
  logic [`ARM_XLEN-1:0]   wb_data;

  arm_stage_if d2e_if ();
  arm_stage_if e2r_if ();

  arm_decode arm_decode_i (
      .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .inst_valid_i (inst_valid_i)
    , .inst_i       (inst_i)
    , .wb_en_i      (wb_en)
    , .wb_addr_i    (wb_addr)
    , .wb_data_i    (wb_data)
    , .dec_o        (d2e_if.dec)
  );

  arm_execute arm_execute_i (
      .clk_i     (clk_i)
    , .reset_i   (reset_i)
    , .dec_i     (d2e_if.exe)
    , .wb_en_i   (wb_en)
    , .wb_addr_i (wb_addr)
    , .wb_data_i (wb_data)
    , .exe_o     (e2r_if.exe_out)
    , .flags_o   (flags_o)
  );

  arm_result arm_result_i (
      .clk_i      (clk_i)
    , .reset_i    (reset_i)
    , .res_i      (e2r_if.res)
    , .wb_en_o    (wb_en)
    , .wb_addr_o  (wb_addr)
    , .wb_data_o  (wb_data)
    , .wb_valid_o (wb_valid_o)
  );

  assign wb_write_o = wb_en;
  assign wb_addr_o  = wb_addr;
  assign wb_data_o  = wb_data;

endmodule

/* arm_core_asserts.sv */
module arm_core_asserts (
    input                   clk_i
  , input                   reset_i
  , input                   inst_valid_i
  , input                   wb_valid_i
  , input                   wb_write_i
  , input arm_pkg::flags_t  flags_i
);

  int fail_cnt = 0;

  // Every reset cycle leaves the outputs idle and the flags clear
  assert property (@(posedge clk_i)
    reset_i |=> !wb_valid_i && !wb_write_i && flags_i == '0)
    else begin
      $error("Core outputs not idle after a reset cycle");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    wb_write_i |-> wb_valid_i)
    else begin
      $error("Register write without a writeback strobe");
      fail_cnt++;
    end

  // Three register stages between strobe and writeback
  assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i, 3) |-> wb_valid_i == $past(inst_valid_i, 3))
    else begin
      $error("Writeback strobe not three cycles after the instruction strobe");
      fail_cnt++;
    end

endmodule

/* arm_core_tb.sv */
`include "arm_consts.svh"

module arm_core_tb;

  localparam int NUM_RECS   = 29;
  localparam int MAX_CYCLES = NUM_RECS * 2 + 20;

  logic                   clk;
  logic                   reset;
  logic                   inst_valid;
  logic [`ARM_XLEN-1:0]   inst;
  logic                   wb_valid;
  logic                   wb_write;
  logic [`ARM_REG_AW-1:0] wb_addr;
  logic [`ARM_XLEN-1:0]   wb_data;
  arm_pkg::flags_t        flags;

  // gap[79:76] inst[75:44] write[43:40] rd[39:36] data[35:4] flags[3:0]
  logic [79:0]            testdata [NUM_RECS];
  logic [43:0]            exp_q [$];
  int                     stamp_q [$];
  int                     cycle_cnt = 0;
  int                     data_errs;
  int                     timing_errs;
  int                     proto_errs;
  logic                   started;
  arm_pkg::flags_t        flags_prev;

  arm_clock_gen arm_clock_gen_i (
      .clk_o   (clk)
    , .reset_o (reset)
  );

  arm_core arm_core_i (
      .clk_i        (clk)
    , .reset_i      (reset)
    , .inst_valid_i (inst_valid)
    , .inst_i       (inst)
    , .wb_valid_o   (wb_valid)
    , .wb_write_o   (wb_write)
    , .wb_addr_o    (wb_addr)
    , .wb_data_o    (wb_data)
    , .flags_o      (flags)
  );

  bind arm_core arm_core_asserts arm_core_asserts_i (
      .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .inst_valid_i (inst_valid_i)
    , .wb_valid_i   (wb_valid_o)
    , .wb_write_i   (wb_write_o)
    , .flags_i      (flags_o)
  );

  // **************************************************
  // Cycle counter and watchdog
  // **************************************************
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // **************************************************
  // Writeback checks
  // **************************************************
  task automatic check_writeback();
    logic [43:0] exp;
    int          stamp;
    if (exp_q.size() == 0) begin
      proto_errs++;
      $display("Writeback arrived with no instruction outstanding");
    end else begin
      exp   = exp_q.pop_front();
      stamp = stamp_q.pop_front();
      if (cycle_cnt - stamp != 3) begin
        timing_errs++;
        $display("Writeback came %0d cycles after its strobe instead of 3",
                 cycle_cnt - stamp);
      end
      if (wb_write !== exp[40]) begin
        data_errs++;
        $display("Error: wb_write_o is %h, expected %h", wb_write, exp[40]);
      end
      if (exp[40] && wb_addr !== exp[39:36]) begin
        data_errs++;
        $display("Error: wb_addr_o is %h, expected %h", wb_addr, exp[39:36]);
      end
      if (exp[40] && wb_data !== exp[35:4]) begin
        data_errs++;
        $display("Error: wb_data_o is %h, expected %h", wb_data, exp[35:4]);
      end
      // Flags settle one cycle before the writeback; by now the next
      // instruction may already have changed them
      if (flags_prev !== exp[3:0]) begin
        data_errs++;
        $display("Error: flags_o is %h, expected %h", flags_prev, exp[3:0]);
      end
    end
  endtask

  task automatic check_outputs();
    if (!reset) begin
      if (wb_write && !wb_valid) begin
        proto_errs++;
        $display("wb_write_o went high without wb_valid_o");
      end
      if (!started && wb_valid) begin
        proto_errs++;
        $display("wb_valid_o went high before the first instruction");
      end
      if (!started && flags != '0) begin
        data_errs++;
        $display("Error: flags_o is %h before the first instruction, expected 0", flags);
      end
      if (wb_valid) begin
        check_writeback();
      end
    end
    flags_prev = flags;
  endtask

  // Outputs are checked first, then new stimulus goes out
  task automatic next_cycle();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic drive_record(input logic [79:0] rec);
    inst_valid = 1'b0;
    repeat (rec[79:76]) next_cycle();
    inst_valid = 1'b1;
    inst       = rec[75:44];
    started    = 1'b1;
    exp_q.push_back(rec[43:0]);
    stamp_q.push_back(cycle_cnt);
    next_cycle();
  endtask

  task automatic finish_run();
    int assert_errs;
    assert_errs = arm_core_i.arm_core_asserts_i.fail_cnt;
    if (exp_q.size() != 0) begin
      proto_errs += exp_q.size();
      $display("%0d instructions never produced a writeback", exp_q.size());
    end
    $display("Errors: data %0d, timing %0d, protocol %0d, assertion %0d",
             data_errs, timing_errs, proto_errs, assert_errs);
    if (data_errs + timing_errs + proto_errs + assert_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // **************************************************
  // Stimulus
  // **************************************************
  initial begin
    inst_valid  = 1'b0;
    inst        = '0;
    data_errs   = 0;
    timing_errs = 0;
    proto_errs  = 0;
    started     = 1'b0;
    flags_prev  = '0;
    $readmemh("arm_core_testdata.txt", testdata);
    wait (reset === 1'b0);
    // Idle window after reset
    repeat (4) next_cycle();
    if ($isunknown(testdata[NUM_RECS-1])) begin
      proto_errs++;
      $display("Test data file is missing or has too few lines");
    end else begin
      for (int i = 0; i < NUM_RECS; i++) begin
        drive_record(testdata[i]);
      end
    end
    inst_valid = 1'b0;
    while (exp_q.size() != 0) next_cycle();
    // Catch stray writebacks
    repeat (4) next_cycle();
    finish_run();
  end

endmodule

/* arm_core_testdata.txt */
// gap_instruction_write_rd_data_flags, all hex, flags as n z c v
// gap is the number of idle cycles before the instruction strobe
0_e3b010ff_1_1_000000ff_0
0_e3b0213f_1_2_c000000f_a
0_e3a03412_1_3_12000000_a
0_e3b04801_1_4_00010000_0
0_e0945003_1_5_12010000_0
0_e0536004_1_6_11ff0000_2
0_e0127001_1_7_0000000f_2
0_e0328001_1_8_c00000f0_a
0_e0719004_1_9_0000ff01_2
0_e0b2a002_1_a_8000001f_a
0_e0d1b002_1_b_400000f0_0
0_e0f4c001_1_c_ffff00fe_8
0_e1130001_0_0_00000000_4
0_e1310002_0_0_00000000_8
0_e1510001_0_0_00000000_6
0_e17b000b_0_0_00000000_9
0_7091d001_0_0_00000000_9
0_a081d001_1_d_000001fe_9
0_e031e001_1_e_00000000_5
0_11b0d002_0_0_00000000_5
1_e19ee007_1_e_0000000f_1
0_e1dcd001_1_d_ffff0000_9
0_e1f0c00d_1_c_0000ffff_1
3_e1b01102_1_1_0000003c_3
0_e1b0322a_1_3_08000001_3
0_e1b04248_1_4_fc00000f_9
0_e1b0546c_1_5_ff0000ff_b
0_b0916001_0_0_00000000_b
0_e0957004_1_7_fb00010e_a

/* arm_decode.sv */
`include "arm_consts.svh"

module arm_decode (
    input                          clk_i
  , input                          reset_i
  , input                          inst_valid_i
  , input        [`ARM_XLEN-1:0]   inst_i
  , input                          wb_en_i
  , input        [`ARM_REG_AW-1:0] wb_addr_i
  , input        [`ARM_XLEN-1:0]   wb_data_i
  , arm_stage_if.dec               dec_o
);

  logic [`ARM_XLEN-1:0]   regs [`ARM_NUM_REGS];
  logic [`ARM_REG_AW-1:0] rn_addr;
  logic [`ARM_REG_AW-1:0] rm_addr;
  logic [`ARM_XLEN-1:0]   rn_rd;
  logic [`ARM_XLEN-1:0]   rm_rd;

  assign rn_addr = inst_i[`ARM_RN_LSB +: `ARM_REG_AW];
  assign rm_addr = inst_i[`ARM_REG_AW-1:0];

  // ************************************************
  // Register file
  // ************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `ARM_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  // Same-cycle write goes straight through to the read
  assign rn_rd = (wb_en_i && wb_addr_i == rn_addr) ? wb_data_i : regs[rn_addr];
  assign rm_rd = (wb_en_i && wb_addr_i == rm_addr) ? wb_data_i : regs[rm_addr];

  // ************************************************
  // Instruction register
  // ************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= inst_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inst_valid_i) begin
      dec_o.cond       <= arm_pkg::cond_e'(inst_i[`ARM_COND_LSB +: 4]);
      // Class 001 is the rotated immediate form
      dec_o.is_imm     <= inst_i[`ARM_CLASS_LSB +: 3] == 3'b001;
      dec_o.opcode     <= arm_pkg::opcode_e'(inst_i[`ARM_OPC_LSB +: 4]);
      dec_o.set_flags  <= inst_i[`ARM_S_BIT];
      dec_o.rn_addr    <= rn_addr;
      dec_o.rd_addr    <= inst_i[`ARM_RD_LSB +: `ARM_REG_AW];
      dec_o.rm_addr    <= rm_addr;
      dec_o.rn_data    <= rn_rd;
      dec_o.rm_data    <= rm_rd;
      dec_o.shift_amt  <= inst_i[11:7];
      dec_o.shift_type <= arm_pkg::shift_e'(inst_i[6:5]);
      dec_o.rot        <= inst_i[11:8];
      dec_o.imm8       <= inst_i[7:0];
    end
  end

endmodule

/* arm_execute.sv */
`include "arm_consts.svh"

module arm_execute (
    input                          clk_i
  , input                          reset_i
  , arm_stage_if.exe               dec_i
  , input                          wb_en_i
  , input        [`ARM_REG_AW-1:0] wb_addr_i
  , input        [`ARM_XLEN-1:0]   wb_data_i
  , arm_stage_if.exe_out           exe_o
  , output arm_pkg::flags_t        flags_o
);

  logic [`ARM_XLEN-1:0]   rn_fwd;
  logic [`ARM_XLEN-1:0]   rm_fwd;
  logic [`ARM_XLEN:0]     lsl_ext;
  logic [`ARM_XLEN:0]     lsr_ext;
  logic [`ARM_XLEN:0]     asr_ext;
  logic [2*`ARM_XLEN-1:0] ror_ext;
  logic [`ARM_XLEN-1:0]   sh_out;
  logic                   sh_carry;
  logic [2*`ARM_XLEN-1:0] imm_ext;
  logic [`ARM_XLEN-1:0]   imm_rot;
  logic                   imm_carry;
  logic [`ARM_XLEN-1:0]   op_b;
  logic                   op_carry;
  logic                   cond_ok;
  logic                   is_arith;
  logic                   is_test;
  logic [`ARM_XLEN-1:0]   arith_x;
  logic [`ARM_XLEN-1:0]   arith_y;
  logic                   arith_cin;
  logic [`ARM_XLEN:0]     sum;
  logic                   overflow;
  logic [`ARM_XLEN-1:0]   alu_res;
  arm_pkg::flags_t        flags_q;
  arm_pkg::flags_t        flags_next;

  // ************************************************
  // Forwarding with the newest value first
  // ************************************************
  always_comb begin
    if (exe_o.valid && exe_o.do_write && exe_o.rd_addr == dec_i.rn_addr)
      rn_fwd = exe_o.data;
    else if (wb_en_i && wb_addr_i == dec_i.rn_addr)
      rn_fwd = wb_data_i;
    else
      rn_fwd = dec_i.rn_data;
    if (exe_o.valid && exe_o.do_write && exe_o.rd_addr == dec_i.rm_addr)
      rm_fwd = exe_o.data;
    else if (wb_en_i && wb_addr_i == dec_i.rm_addr)
      rm_fwd = wb_data_i;
    else
      rm_fwd = dec_i.rm_data;
  end

  // ************************************************
  // Second operand
  // ************************************************
  // Extra bit beside the data catches the last bit shifted out
  assign lsl_ext = {1'b0, rm_fwd} << dec_i.shift_amt;
  assign lsr_ext = {rm_fwd, 1'b0} >> dec_i.shift_amt;
  assign asr_ext = $signed({rm_fwd, 1'b0}) >>> dec_i.shift_amt;
  assign ror_ext = {rm_fwd, rm_fwd} >> dec_i.shift_amt;

  always_comb begin
    case (dec_i.shift_type)
      arm_pkg::sh_lsl: begin
        sh_out   = lsl_ext[`ARM_XLEN-1:0];
        sh_carry = (dec_i.shift_amt == '0) ? flags_q.c : lsl_ext[`ARM_XLEN];
      end
      arm_pkg::sh_lsr: begin
        // Amount 0 encodes LSR #32
        sh_out   = (dec_i.shift_amt == '0) ? '0 : lsr_ext[`ARM_XLEN:1];
        sh_carry = (dec_i.shift_amt == '0) ? rm_fwd[`ARM_XLEN-1] : lsr_ext[0];
      end
      arm_pkg::sh_asr: begin
        sh_out   = (dec_i.shift_amt == '0) ? {`ARM_XLEN{rm_fwd[`ARM_XLEN-1]}}
                                           : asr_ext[`ARM_XLEN:1];
        sh_carry = (dec_i.shift_amt == '0) ? rm_fwd[`ARM_XLEN-1] : asr_ext[0];
      end
      default: begin
        // ROR #0 is RRX through the carry
        sh_out   = (dec_i.shift_amt == '0) ? {flags_q.c, rm_fwd[`ARM_XLEN-1:1]}
                                           : ror_ext[`ARM_XLEN-1:0];
        sh_carry = (dec_i.shift_amt == '0) ? rm_fwd[0] : ror_ext[`ARM_XLEN-1];
      end
    endcase
  end

  // Immediate rotated right by twice rot
  assign imm_ext   = {{(`ARM_XLEN-8){1'b0}}, dec_i.imm8, {(`ARM_XLEN-8){1'b0}}, dec_i.imm8}
                     >> {dec_i.rot, 1'b0};
  assign imm_rot   = imm_ext[`ARM_XLEN-1:0];
  assign imm_carry = (dec_i.rot == '0) ? flags_q.c : imm_rot[`ARM_XLEN-1];

  assign op_b     = dec_i.is_imm ? imm_rot : sh_out;
  assign op_carry = dec_i.is_imm ? imm_carry : sh_carry;

  // ************************************************
  // Condition check
  // ************************************************
  always_comb begin
    case (dec_i.cond)
      arm_pkg::cond_eq: cond_ok = flags_q.z;
      arm_pkg::cond_ne: cond_ok = !flags_q.z;
      arm_pkg::cond_cs: cond_ok = flags_q.c;
      arm_pkg::cond_cc: cond_ok = !flags_q.c;
      arm_pkg::cond_mi: cond_ok = flags_q.n;
      arm_pkg::cond_pl: cond_ok = !flags_q.n;
      arm_pkg::cond_vs: cond_ok = flags_q.v;
      arm_pkg::cond_vc: cond_ok = !flags_q.v;
      arm_pkg::cond_hi: cond_ok = flags_q.c && !flags_q.z;
      arm_pkg::cond_ls: cond_ok = !flags_q.c || flags_q.z;
      arm_pkg::cond_ge: cond_ok = flags_q.n == flags_q.v;
      arm_pkg::cond_lt: cond_ok = flags_q.n != flags_q.v;
      arm_pkg::cond_gt: cond_ok = !flags_q.z && (flags_q.n == flags_q.v);
      arm_pkg::cond_le: cond_ok = flags_q.z || (flags_q.n != flags_q.v);
      arm_pkg::cond_al: cond_ok = 1'b1;
      default:          cond_ok = 1'b0;
    endcase
  end

  // ************************************************
  // ALU
  // ************************************************
  // Every arithmetic opcode reduces to x + y + cin
  always_comb begin
    arith_x   = rn_fwd;
    arith_y   = op_b;
    arith_cin = 1'b0;
    is_arith  = 1'b1;
    case (dec_i.opcode)
      arm_pkg::op_add, arm_pkg::op_cmn: arith_cin = 1'b0;
      arm_pkg::op_adc: arith_cin = flags_q.c;
      arm_pkg::op_sub, arm_pkg::op_cmp: begin
        arith_y   = ~op_b;
        arith_cin = 1'b1;
      end
      arm_pkg::op_sbc: begin
        arith_y   = ~op_b;
        arith_cin = flags_q.c;
      end
      arm_pkg::op_rsb: begin
        arith_x   = op_b;
        arith_y   = ~rn_fwd;
        arith_cin = 1'b1;
      end
      arm_pkg::op_rsc: begin
        arith_x   = op_b;
        arith_y   = ~rn_fwd;
        arith_cin = flags_q.c;
      end
      default: is_arith = 1'b0;
    endcase
  end

  assign sum      = {1'b0, arith_x} + {1'b0, arith_y} + {{`ARM_XLEN{1'b0}}, arith_cin};
  assign overflow = (arith_x[`ARM_XLEN-1] == arith_y[`ARM_XLEN-1])
                    && (sum[`ARM_XLEN-1] != arith_x[`ARM_XLEN-1]);

  always_comb begin
    case (dec_i.opcode)
      arm_pkg::op_and, arm_pkg::op_tst: alu_res = rn_fwd & op_b;
      arm_pkg::op_eor, arm_pkg::op_teq: alu_res = rn_fwd ^ op_b;
      arm_pkg::op_orr: alu_res = rn_fwd | op_b;
      arm_pkg::op_mov: alu_res = op_b;
      arm_pkg::op_bic: alu_res = rn_fwd & ~op_b;
      arm_pkg::op_mvn: alu_res = ~op_b;
      default:         alu_res = sum[`ARM_XLEN-1:0];
    endcase
  end

  assign is_test = dec_i.opcode inside {arm_pkg::op_tst, arm_pkg::op_teq,
                                        arm_pkg::op_cmp, arm_pkg::op_cmn};

  // Logical opcodes keep V and take C from the shifter
  assign flags_next.n = alu_res[`ARM_XLEN-1];
  assign flags_next.z = alu_res == '0;
  assign flags_next.c = is_arith ? sum[`ARM_XLEN] : op_carry;
  assign flags_next.v = is_arith ? overflow : flags_q.v;

  // ************************************************
  // Output and flags registers
  // ************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_o.valid    <= 1'b0;
      exe_o.do_write <= 1'b0;
      flags_q        <= '0;
    end else begin
      exe_o.valid    <= dec_i.valid;
      exe_o.do_write <= dec_i.valid && cond_ok && !is_test;
      if (dec_i.valid && cond_ok && dec_i.set_flags)
        flags_q <= flags_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_i.valid) begin
      exe_o.rd_addr <= dec_i.rd_addr;
      exe_o.data    <= alu_res;
    end
  end

  assign flags_o = flags_q;

endmodule

/* arm_pkg.sv */
package arm_pkg;

  // Data-processing opcodes
  typedef enum logic [3:0] {
    op_and = 4'b0000,
    op_eor = 4'b0001,
    op_sub = 4'b0010,
    op_rsb = 4'b0011,
    op_add = 4'b0100,
    op_adc = 4'b0101,
    op_sbc = 4'b0110,
    op_rsc = 4'b0111,
    op_tst = 4'b1000,
    op_teq = 4'b1001,
    op_cmp = 4'b1010,
    op_cmn = 4'b1011,
    op_orr = 4'b1100,
    op_mov = 4'b1101,
    op_bic = 4'b1110,
    op_mvn = 4'b1111
  } opcode_e;

  typedef enum logic [1:0] {
    sh_lsl = 2'b00,
    sh_lsr = 2'b01,
    sh_asr = 2'b10,
    sh_ror = 2'b11
  } shift_e;

  // 1111 never executes
  typedef enum logic [3:0] {
    cond_eq = 4'b0000,
    cond_ne = 4'b0001,
    cond_cs = 4'b0010,
    cond_cc = 4'b0011,
    cond_mi = 4'b0100,
    cond_pl = 4'b0101,
    cond_vs = 4'b0110,
    cond_vc = 4'b0111,
    cond_hi = 4'b1000,
    cond_ls = 4'b1001,
    cond_ge = 4'b1010,
    cond_lt = 4'b1011,
    cond_gt = 4'b1100,
    cond_le = 4'b1101,
    cond_al = 4'b1110,
    cond_nv = 4'b1111
  } cond_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

endpackage

/* arm_result.sv */
`include "arm_consts.svh"

module arm_result (
    input                          clk_i
  , input                          reset_i
  , arm_stage_if.res               res_i
  , output logic                   wb_en_o
  , output logic [`ARM_REG_AW-1:0] wb_addr_o
  , output logic [`ARM_XLEN-1:0]   wb_data_o
  , output logic                   wb_valid_o
);

  logic load_data;

  // Only a real write moves the data register
  assign load_data = res_i.valid && res_i.do_write;

  // ************************************************
  // Writeback register
  // ************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o <= 1'b0;
      wb_en_o    <= 1'b0;
    end else begin
      wb_valid_o <= res_i.valid;
      wb_en_o    <= load_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_i.valid) begin
      wb_addr_o <= res_i.rd_addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_data) begin
      wb_data_o <= res_i.data;
    end
  end

endmodule

/* arm_stage_if.sv */
`include "arm_consts.svh"

interface arm_stage_if;

  // Shared between both hops
  logic                      valid;
  logic [`ARM_REG_AW-1:0]    rd_addr;

  // Decoded instruction and operands
  arm_pkg::opcode_e          opcode;
  logic                      is_imm;
  logic                      set_flags;
  arm_pkg::cond_e            cond;
  logic [`ARM_REG_AW-1:0]    rn_addr;
  logic [`ARM_REG_AW-1:0]    rm_addr;
  logic [`ARM_XLEN-1:0]      rn_data;
  logic [`ARM_XLEN-1:0]      rm_data;
  arm_pkg::shift_e           shift_type;
  logic [4:0]                shift_amt;
  logic [7:0]                imm8;
  logic [3:0]                rot;

  // Execute result
  logic                      do_write;
  logic [`ARM_XLEN-1:0]      data;

  modport dec (output valid, opcode, is_imm, set_flags, cond, rn_addr, rm_addr, rd_addr,
               rn_data, rm_data, shift_type, shift_amt, imm8, rot);
  modport exe (input valid, opcode, is_imm, set_flags, cond, rn_addr, rm_addr, rd_addr,
               rn_data, rm_data, shift_type, shift_amt, imm8, rot);

  modport exe_out (output valid, do_write, rd_addr, data);
  modport res (input valid, do_write, rd_addr, data);

endinterface

/* tb.f */
+incdir+.
arm_pkg.sv
arm_stage_if.sv
arm_decode.sv
arm_execute.sv
arm_result.sv
arm_core.sv
arm_clock_gen.sv
arm_core_asserts.sv
arm_core_tb.sv
